// ==== include/bin_consts.svh ====
//--------------------------------------------------------------------------
// widths, register map and reset values of the image binarizer
// included by the package and by every block that needs one of them
//--------------------------------------------------------------------------
`ifndef BIN_CONSTS_SVH
`define BIN_CONSTS_SVH

`define BIN_DATA_WIDTH       8
`define BIN_BINARY_WIDTH     2
`define BIN_USER_WIDTH       4
`define BIN_INDEX_WIDTH      2
`define BIN_WB_ADR_WIDTH     8
`define BIN_WB_DAT_WIDTH     32
`define BIN_PIPE_LATENCY     3

`define BIN_CORE_ID          32'h527a_0120
`define BIN_CORE_VERSION     32'h0001_0000

// register map, word addresses
`define BIN_ADR_CORE_ID      8'h00
`define BIN_ADR_CORE_VERSION 8'h01
`define BIN_ADR_CTL_CONTROL  8'h04
`define BIN_ADR_CTL_STATUS   8'h05
`define BIN_ADR_CTL_INDEX    8'h07
`define BIN_ADR_PARAM_TH     8'h08
`define BIN_ADR_PARAM_INV    8'h09
`define BIN_ADR_PARAM_VAL0   8'h0a
`define BIN_ADR_PARAM_VAL1   8'h0b
`define BIN_ADR_CURRENT_TH   8'h18
`define BIN_ADR_CURRENT_INV  8'h19
`define BIN_ADR_CURRENT_VAL0 8'h1a
`define BIN_ADR_CURRENT_VAL1 8'h1b

// control bits: 0 enable, 1 update request, 2 auto clear
`define BIN_INIT_CONTROL     3'b011
`define BIN_INIT_TH          8'd127
`define BIN_INIT_INV         1'b0
`define BIN_INIT_VAL0        {`BIN_BINARY_WIDTH{1'b0}}
`define BIN_INIT_VAL1        {`BIN_BINARY_WIDTH{1'b1}}

`endif

// ==== rtl/bin_pkg.sv ====
//--------------------------------------------------------------------------
// data types shared by the binarizer blocks and the testbench
//--------------------------------------------------------------------------
`include "bin_consts.svh"

package bin_pkg;

    typedef logic [`BIN_DATA_WIDTH-1:0]   pixel_t;
    typedef logic [`BIN_BINARY_WIDTH-1:0] binary_t;
    typedef logic [`BIN_USER_WIDTH-1:0]   user_t;
    typedef logic [`BIN_INDEX_WIDTH-1:0]  index_t;
    typedef logic [`BIN_WB_DAT_WIDTH-1:0] wb_word_t;

    // per-pixel side information, travels beside the data word
    typedef struct packed {
        logic  de;
        logic  line_first;
        logic  line_last;
        logic  pixel_first;
        logic  pixel_last;
        user_t user;
    } img_sync_t;

endpackage

// ==== rtl/bin_wb_regs.sv ====
//--------------------------------------------------------------------------
// Wishbone classic register block of the binarizer
// holds the working parameters and reads back the ones in use
//--------------------------------------------------------------------------
`include "bin_consts.svh"

module bin_wb_regs (
    input  logic                           s_wb_clk_i,
    input  logic                           s_wb_rst_i,
    input  logic                           s_wb_cyc_i,
    input  logic                           s_wb_stb_i,
    input  logic                           s_wb_we_i,
    input  logic [`BIN_WB_ADR_WIDTH-1:0]   s_wb_adr_i,
    input  bin_pkg::wb_word_t              s_wb_dat_i,
    input  logic [`BIN_WB_DAT_WIDTH/8-1:0] s_wb_sel_i,
    input  logic                           update_ack_i,
    input  logic                           cur_enable_i,
    input  bin_pkg::pixel_t                cur_th_i,
    input  logic                           cur_inv_i,
    input  bin_pkg::binary_t               cur_val0_i,
    input  bin_pkg::binary_t               cur_val1_i,
    input  bin_pkg::index_t                index_i,
    output bin_pkg::wb_word_t              s_wb_dat_o,
    output logic                           s_wb_ack_o,
    output logic                           enable_o,
    output logic                           update_req_o,
    output bin_pkg::pixel_t                th_o,
    output logic                           inv_o,
    output bin_pkg::binary_t               val0_o,
    output bin_pkg::binary_t               val1_o
);
    import bin_pkg::*;

    logic [2:0] ctl_q;
    pixel_t     th_q;
    logic       inv_q;
    binary_t    val0_q;
    binary_t    val1_q;
    wb_word_t   rd_word;
    logic       wb_hit;

    // byte lanes not selected keep the old register contents
    function automatic wb_word_t wr_merge(input wb_word_t old_w);
        wb_word_t res;
        for (int i = 0; i < `BIN_WB_DAT_WIDTH / 8; i++) begin
            res[i*8 +: 8] = s_wb_sel_i[i] ? s_wb_dat_i[i*8 +: 8] : old_w[i*8 +: 8];
        end
        return res;
    endfunction

    // one ack per access, dropped even if the master still holds stb
    assign wb_hit = s_wb_cyc_i & s_wb_stb_i & ~s_wb_ack_o;

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            s_wb_ack_o <= 1'b0;
            ctl_q      <= `BIN_INIT_CONTROL;
            th_q       <= `BIN_INIT_TH;
            inv_q      <= `BIN_INIT_INV;
            val0_q     <= `BIN_INIT_VAL0;
            val1_q     <= `BIN_INIT_VAL1;
        end else begin
            s_wb_ack_o <= wb_hit;
            // auto clear of the request once the shadow took it
            if (update_ack_i && ctl_q[2]) begin
                ctl_q[1] <= 1'b0;
            end
            if (wb_hit && s_wb_we_i) begin
                case (s_wb_adr_i)
                    `BIN_ADR_CTL_CONTROL: ctl_q  <= 3'(wr_merge(wb_word_t'(ctl_q)));
                    `BIN_ADR_PARAM_TH:    th_q   <= pixel_t'(wr_merge(wb_word_t'(th_q)));
                    `BIN_ADR_PARAM_INV:   inv_q  <= 1'(wr_merge(wb_word_t'(inv_q)));
                    `BIN_ADR_PARAM_VAL0:  val0_q <= binary_t'(wr_merge(wb_word_t'(val0_q)));
                    `BIN_ADR_PARAM_VAL1:  val1_q <= binary_t'(wr_merge(wb_word_t'(val1_q)));
                    default: ;
                endcase
            end
        end
    end

    //----------------------------------------------------------------------
    // readback
    //----------------------------------------------------------------------
    always_comb begin
        case (s_wb_adr_i)
            `BIN_ADR_CORE_ID:      rd_word = `BIN_CORE_ID;
            `BIN_ADR_CORE_VERSION: rd_word = `BIN_CORE_VERSION;
            `BIN_ADR_CTL_CONTROL:  rd_word = wb_word_t'(ctl_q);
            `BIN_ADR_CTL_STATUS:   rd_word = wb_word_t'(cur_enable_i);
            `BIN_ADR_CTL_INDEX:    rd_word = wb_word_t'(index_i);
            `BIN_ADR_PARAM_TH:     rd_word = wb_word_t'(th_q);
            `BIN_ADR_PARAM_INV:    rd_word = wb_word_t'(inv_q);
            `BIN_ADR_PARAM_VAL0:   rd_word = wb_word_t'(val0_q);
            `BIN_ADR_PARAM_VAL1:   rd_word = wb_word_t'(val1_q);
            `BIN_ADR_CURRENT_TH:   rd_word = wb_word_t'(cur_th_i);
            `BIN_ADR_CURRENT_INV:  rd_word = wb_word_t'(cur_inv_i);
            `BIN_ADR_CURRENT_VAL0: rd_word = wb_word_t'(cur_val0_i);
            `BIN_ADR_CURRENT_VAL1: rd_word = wb_word_t'(cur_val1_i);
            default:               rd_word = '0;
        endcase
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (wb_hit) begin
            s_wb_dat_o <= rd_word;
        end
    end

    assign enable_o     = ctl_q[0];
    assign update_req_o = ctl_q[1];
    assign th_o         = th_q;
    assign inv_o        = inv_q;
    assign val0_o       = val0_q;
    assign val1_o       = val1_q;

    ack_one_cycle: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        s_wb_ack_o |=> !s_wb_ack_o);

endmodule

// ==== rtl/bin_param_shadow.sv ====
//--------------------------------------------------------------------------
// shadow stage, swaps in the working parameters at a frame start
// while an update is requested, then acks and counts the load
//--------------------------------------------------------------------------
`include "bin_consts.svh"

module bin_param_shadow (
    input  logic              s_wb_clk_i,
    input  logic              s_wb_rst_i,
    input  logic              valid_i,
    input  logic              line_first_i,
    input  logic              pixel_first_i,
    input  logic              update_req_i,
    input  logic              enable_i,
    input  bin_pkg::pixel_t   th_i,
    input  logic              inv_i,
    input  bin_pkg::binary_t  val0_i,
    input  bin_pkg::binary_t  val1_i,
    output logic              update_ack_o,
    output bin_pkg::index_t   index_o,
    output logic              cur_enable_o,
    output bin_pkg::pixel_t   cur_th_o,
    output logic              cur_inv_o,
    output bin_pkg::binary_t  cur_val0_o,
    output bin_pkg::binary_t  cur_val1_o
);
    import bin_pkg::*;

    logic    load;
    logic    en_q;
    pixel_t  th_q;
    logic    inv_q;
    binary_t val0_q;
    binary_t val1_q;

    assign load = valid_i & line_first_i & pixel_first_i & update_req_i;

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            update_ack_o <= 1'b0;
            index_o      <= '0;
            en_q         <= 1'b0;
            th_q         <= `BIN_INIT_TH;
            inv_q        <= `BIN_INIT_INV;
            val0_q       <= `BIN_INIT_VAL0;
            val1_q       <= `BIN_INIT_VAL1;
        end else begin
            update_ack_o <= load;
            if (load) begin
                index_o <= index_o + 1'b1;
                en_q    <= enable_i;
                th_q    <= th_i;
                inv_q   <= inv_i;
                val0_q  <= val0_i;
                val1_q  <= val1_i;
            end
        end
    end

    // the frame-start pixel itself already sees the new set
    assign cur_enable_o = load ? enable_i : en_q;
    assign cur_th_o     = load ? th_i     : th_q;
    assign cur_inv_o    = load ? inv_i    : inv_q;
    assign cur_val0_o   = load ? val0_i   : val0_q;
    assign cur_val1_o   = load ? val1_i   : val1_q;

    ack_while_req: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        update_ack_o |-> update_req_i);

endmodule

// ==== rtl/bin_threshold_pipe.sv ====
//--------------------------------------------------------------------------
// two-stage threshold compare and output code select
//--------------------------------------------------------------------------
module bin_threshold_pipe (
    input  logic              s_wb_clk_i,
    input  logic              s_wb_rst_i,
    input  bin_pkg::pixel_t   data_i,
    input  logic              enable_i,
    input  bin_pkg::pixel_t   th_i,
    input  logic              inv_i,
    input  bin_pkg::binary_t  val0_i,
    input  bin_pkg::binary_t  val1_i,
    output bin_pkg::binary_t  binary_o
);
    import bin_pkg::*;

    logic    hit_q;
    logic    en_q;
    binary_t val0_q;
    binary_t val1_q;

    // stage 1, compare and keep this pixel's codes with it
    always_ff @(posedge s_wb_clk_i) begin
        hit_q  <= (data_i >= th_i) ^ inv_i;
        val0_q <= val0_i;
        val1_q <= val1_i;
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            en_q     <= 1'b0;
            binary_o <= '0;
        end else begin
            en_q <= enable_i;
            // stage 2, disabled core always gives val0
            binary_o <= (en_q && hit_q) ? val1_q : val0_q;
        end
    end

endmodule

// ==== rtl/img_delay_line.sv ====
//--------------------------------------------------------------------------
// two-deep register chain for any packed payload
// keeps stream side data in step with the threshold pipe
//--------------------------------------------------------------------------
module img_delay_line #(
    parameter type T = bin_pkg::pixel_t
) (
    input  logic s_wb_clk_i,
    input  logic s_wb_rst_i,
    input  T     d_i,
    output T     q_o
);

    T stage1_q;
    T stage2_q;

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            stage1_q <= '0;
            stage2_q <= '0;
        end else begin
            stage1_q <= d_i;
            stage2_q <= stage1_q;
        end
    end

    assign q_o = stage2_q;

endmodule

// ==== rtl/bin_output_merge.sv ====
//--------------------------------------------------------------------------
// output register, joins the delayed pixel with its binary code
//--------------------------------------------------------------------------
module bin_output_merge (
    input  logic               s_wb_clk_i,
    input  logic               s_wb_rst_i,
    input  logic               valid_i,
    input  bin_pkg::img_sync_t sync_i,
    input  bin_pkg::pixel_t    data_i,
    input  bin_pkg::binary_t   binary_i,
    output logic               valid_o,
    output logic               de_o,
    output logic               line_first_o,
    output logic               line_last_o,
    output logic               pixel_first_o,
    output logic               pixel_last_o,
    output bin_pkg::user_t     user_o,
    output bin_pkg::pixel_t    data_o,
    output bin_pkg::binary_t   binary_o
);

    // flags only mean something on a valid cycle
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            valid_o       <= 1'b0;
            de_o          <= 1'b0;
            line_first_o  <= 1'b0;
            line_last_o   <= 1'b0;
            pixel_first_o <= 1'b0;
            pixel_last_o  <= 1'b0;
        end else begin
            valid_o       <= valid_i;
            de_o          <= valid_i & sync_i.de;
            line_first_o  <= valid_i & sync_i.line_first;
            line_last_o   <= valid_i & sync_i.line_last;
            pixel_first_o <= valid_i & sync_i.pixel_first;
            pixel_last_o  <= valid_i & sync_i.pixel_last;
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        user_o   <= sync_i.user;
        data_o   <= data_i;
        binary_o <= valid_i ? binary_i : '0;
    end

    first_is_valid: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        pixel_first_o |-> valid_o);

endmodule

// ==== rtl/img_binarizer_top.sv ====
//--------------------------------------------------------------------------
// image binarizer top, register port, parameter shadow and pixel path
// output appears three cycles after the input pixel
//--------------------------------------------------------------------------
`include "bin_consts.svh"

module img_binarizer_top (
    input  logic                           s_wb_clk_i,
    input  logic                           s_wb_rst_i,
    input  logic                           s_wb_cyc_i,
    input  logic                           s_wb_stb_i,
    input  logic                           s_wb_we_i,
    input  logic [`BIN_WB_ADR_WIDTH-1:0]   s_wb_adr_i,
    input  bin_pkg::wb_word_t              s_wb_dat_i,
    input  logic [`BIN_WB_DAT_WIDTH/8-1:0] s_wb_sel_i,
    output bin_pkg::wb_word_t              s_wb_dat_o,
    output logic                           s_wb_ack_o,
    input  logic                           valid_i,
    input  logic                           de_i,
    input  logic                           line_first_i,
    input  logic                           line_last_i,
    input  logic                           pixel_first_i,
    input  logic                           pixel_last_i,
    input  bin_pkg::user_t                 user_i,
    input  bin_pkg::pixel_t                data_i,
    output logic                           valid_o,
    output logic                           de_o,
    output logic                           line_first_o,
    output logic                           line_last_o,
    output logic                           pixel_first_o,
    output logic                           pixel_last_o,
    output bin_pkg::user_t                 user_o,
    output bin_pkg::pixel_t                data_o,
    output bin_pkg::binary_t               binary_o
);
    import bin_pkg::*;

    // valid rides along with the sync flags
    typedef struct packed {
        logic      valid;
        img_sync_t sync;
    } vsync_t;

    logic    enable, update_req, update_ack, inv;
    pixel_t  th;
    binary_t val0, val1;
    logic    cur_enable, cur_inv;
    pixel_t  cur_th;
    binary_t cur_val0, cur_val1;
    index_t  index;
    vsync_t  vs_in, vs_dly;
    pixel_t  data_dly;
    binary_t binary;

    assign vs_in.valid            = valid_i;
    assign vs_in.sync.de          = de_i;
    assign vs_in.sync.line_first  = line_first_i;
    assign vs_in.sync.line_last   = line_last_i;
    assign vs_in.sync.pixel_first = pixel_first_i;
    assign vs_in.sync.pixel_last  = pixel_last_i;
    assign vs_in.sync.user        = user_i;

    bin_wb_regs u_regs (
        .s_wb_clk_i, .s_wb_rst_i, .s_wb_cyc_i, .s_wb_stb_i, .s_wb_we_i,
        .s_wb_adr_i, .s_wb_dat_i, .s_wb_sel_i, .s_wb_dat_o, .s_wb_ack_o,
        .update_ack_i (update_ack),
        .cur_enable_i (cur_enable),
        .cur_th_i     (cur_th),
        .cur_inv_i    (cur_inv),
        .cur_val0_i   (cur_val0),
        .cur_val1_i   (cur_val1),
        .index_i      (index),
        .enable_o     (enable),
        .update_req_o (update_req),
        .th_o         (th),
        .inv_o        (inv),
        .val0_o       (val0),
        .val1_o       (val1)
    );

    bin_param_shadow u_shadow (
        .s_wb_clk_i, .s_wb_rst_i, .valid_i, .line_first_i, .pixel_first_i,
        .update_req_i (update_req),
        .enable_i     (enable),
        .th_i         (th),
        .inv_i        (inv),
        .val0_i       (val0),
        .val1_i       (val1),
        .update_ack_o (update_ack),
        .index_o      (index),
        .cur_enable_o (cur_enable),
        .cur_th_o     (cur_th),
        .cur_inv_o    (cur_inv),
        .cur_val0_o   (cur_val0),
        .cur_val1_o   (cur_val1)
    );

    bin_threshold_pipe u_thresh (
        .s_wb_clk_i, .s_wb_rst_i, .data_i,
        .enable_i (cur_enable),
        .th_i     (cur_th),
        .inv_i    (cur_inv),
        .val0_i   (cur_val0),
        .val1_i   (cur_val1),
        .binary_o (binary)
    );

    img_delay_line #(.T(pixel_t)) u_data_dly (
        .s_wb_clk_i, .s_wb_rst_i,
        .d_i (data_i),
        .q_o (data_dly)
    );

    img_delay_line #(.T(vsync_t)) u_sync_dly (
        .s_wb_clk_i, .s_wb_rst_i,
        .d_i (vs_in),
        .q_o (vs_dly)
    );

    bin_output_merge u_merge (
        .s_wb_clk_i, .s_wb_rst_i,
        .valid_i  (vs_dly.valid),
        .sync_i   (vs_dly.sync),
        .data_i   (data_dly),
        .binary_i (binary),
        .valid_o, .de_o, .line_first_o, .line_last_o, .pixel_first_o,
        .pixel_last_o, .user_o, .data_o, .binary_o
    );

endmodule

// ==== tb/tb_img_binarizer.sv ====
//--------------------------------------------------------------------------
// vector driven testbench of the image binarizer
// register and pixel operations come from the vectors file, one per line
//--------------------------------------------------------------------------
`include "bin_consts.svh"

module tb_img_binarizer;
    import bin_pkg::*;

    typedef struct {
        int        due;
        img_sync_t sync;
        pixel_t    data;
        binary_t   code;
    } expect_t;

    logic                           s_wb_clk_i, s_wb_rst_i;
    logic                           s_wb_cyc_i, s_wb_stb_i, s_wb_we_i;
    logic [`BIN_WB_ADR_WIDTH-1:0]   s_wb_adr_i;
    wb_word_t                       s_wb_dat_i, s_wb_dat_o;
    logic [`BIN_WB_DAT_WIDTH/8-1:0] s_wb_sel_i;
    logic                           s_wb_ack_o;
    logic                           valid_i, de_i, line_first_i, line_last_i;
    logic                           pixel_first_i, pixel_last_i;
    user_t                          user_i;
    pixel_t                         data_i;
    logic                           valid_o, de_o, line_first_o, line_last_o;
    logic                           pixel_first_o, pixel_last_o;
    user_t                          user_o;
    pixel_t                         data_o;
    binary_t                        binary_o;

    expect_t   pending[$];
    expect_t   head;
    img_sync_t seen;
    int        cyc_cnt, errors, checks, test_errors;
    bit        aborted;
    integer    seed;
    string     test_name;

    img_binarizer_top dut0 (.*);

    always #20 s_wb_clk_i = ~s_wb_clk_i;

    always @(posedge s_wb_clk_i) cyc_cnt <= cyc_cnt + 1;

    //----------------------------------------------------------------------
    // result checks
    //----------------------------------------------------------------------
    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string what, input wb_word_t got, input wb_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_binary(input string what, input binary_t got, input binary_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_sync(input string what, input img_sync_t got, input img_sync_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            count_error();
        end
    endtask

    // output side, stable at the falling edge
    always @(negedge s_wb_clk_i) begin
        if (pending.size() > 0 && pending[0].due == cyc_cnt) begin
            head = pending.pop_front();
            if (!valid_o) begin
                $display("pixel %h due at cycle %0d did not come out", head.data, head.due);
                count_error();
            end else begin
                seen = {de_o, line_first_o, line_last_o, pixel_first_o, pixel_last_o, user_o};
                check_sync("output flags and user", seen, head.sync);
                check_pixel("output data", data_o, head.data);
                check_binary("binary code", binary_o, head.code);
            end
        end else if (valid_o) begin
            $display("valid output at cycle %0d with no pixel due", cyc_cnt);
            count_error();
        end
    end

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    //----------------------------------------------------------------------
    // drivers
    //----------------------------------------------------------------------
    task automatic bus_access(input logic we, input logic [7:0] adr, input wb_word_t wdat,
                              output wb_word_t rdat);
        int waited;
        s_wb_cyc_i = 1'b1;
        s_wb_stb_i = 1'b1;
        s_wb_we_i  = we;
        s_wb_adr_i = adr;
        s_wb_dat_i = wdat;
        s_wb_sel_i = '1;
        waited     = 0;
        do begin
            @(negedge s_wb_clk_i);
            waited++;
        end while (!s_wb_ack_o && waited < 16);
        if (!s_wb_ack_o) begin
            $display("no Wishbone ack within 16 cycles at address %h", adr);
            count_error();
            aborted = 1'b1;
            rdat    = '0;
        end else begin
            rdat = s_wb_dat_o;
            @(posedge s_wb_clk_i);
            #1;
        end
        s_wb_cyc_i = 1'b0;
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
    endtask

    task automatic send_pixel(input logic [4:0] flags, input user_t user, input pixel_t data,
                              input binary_t code);
        expect_t e;
        int      gap;
        valid_i = 1'b1;
        {de_i, line_first_i, line_last_i, pixel_first_i, pixel_last_i} = flags;
        user_i  = user;
        data_i  = data;
        e.due   = cyc_cnt + `BIN_PIPE_LATENCY;
        e.sync  = {flags, user};
        e.data  = data;
        e.code  = code;
        pending.push_back(e);
        @(posedge s_wb_clk_i);
        #1;
        valid_i = 1'b0;
        {de_i, line_first_i, line_last_i, pixel_first_i, pixel_last_i} = 5'b0;
        user_i  = '0;
        data_i  = pixel_t'($random(seed));
        gap     = $unsigned($random(seed)) % 3;
        repeat (gap) begin
            @(posedge s_wb_clk_i);
            #1;
        end
    endtask

    task automatic drain_pixels();
        int waited;
        waited = 0;
        while (pending.size() > 0 && waited < 8) begin
            @(posedge s_wb_clk_i);
            #1;
            waited++;
        end
        if (pending.size() > 0) begin
            $display("pixels still in the pipeline after 8 cycles");
            count_error();
            aborted = 1'b1;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            drain_pixels();
            if (test_errors == 0) begin
                $display("test %s passed", test_name);
            end else begin
                $display("test %s failed with %0d errors", test_name, test_errors);
            end
            test_errors = 0;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       tok;
        logic [31:0] f1, f2, f3, f4;
        wb_word_t    rd;
        s_wb_clk_i = 1'b0;
        s_wb_rst_i = 1'b1;
        s_wb_cyc_i = 1'b0;
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
        s_wb_adr_i = '0;
        s_wb_dat_i = '0;
        s_wb_sel_i = '0;
        {valid_i, de_i, line_first_i, line_last_i, pixel_first_i, pixel_last_i} = 6'b0;
        user_i     = '0;
        data_i     = '0;
        seed       = 32'hddd7;
        test_name  = "";
        aborted    = 1'b0;
        fd = $fopen("tb/tb_img_binarizer_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vectors file");
            count_error();
            aborted = 1'b1;
        end
        repeat (3) @(posedge s_wb_clk_i);
        #1;
        s_wb_rst_i = 1'b0;
        check_flag("valid_o after reset", valid_o, 1'b0);
        check_flag("ack after reset", s_wb_ack_o, 1'b0);

        while (!aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                n = $sscanf(line, "%s %h %h %h %h", tok, f1, f2, f3, f4);
                if (tok == "T") begin
                    close_test();
                    n = $sscanf(line, "%s %s", tok, test_name);
                end else if (tok == "W") begin
                    bus_access(1'b1, f1[7:0], f2, rd);
                end else if (tok == "R") begin
                    drain_pixels();
                    bus_access(1'b0, f1[7:0], '0, rd);
                    if (!aborted) begin
                        check_word($sformatf("register %h", f1[7:0]), rd, f2);
                    end
                end else if (tok == "P") begin
                    send_pixel(f1[4:0], f2[`BIN_USER_WIDTH-1:0], f3[`BIN_DATA_WIDTH-1:0],
                               f4[`BIN_BINARY_WIDTH-1:0]);
                end else begin
                    $display("unknown operation in the vectors file: %s", line);
                    count_error();
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!aborted) begin
            close_test();
        end
        finish_run();
    end

endmodule

// ==== all.f ====
+incdir+include
rtl/bin_pkg.sv
rtl/bin_wb_regs.sv
rtl/bin_param_shadow.sv
rtl/bin_threshold_pipe.sv
rtl/img_delay_line.sv
rtl/bin_output_merge.sv
rtl/img_binarizer_top.sv
tb/tb_img_binarizer.sv

// ==== Makefile ====
# Verilator build and run of the image binarizer testbench
# override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_img_binarizer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS
FAIL_MSG  ?= ERRORS FOUND

SRCS := $(filter-out +incdir%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_img_binarizer_vectors.txt ====
# T name | W adr data | R adr expected | P flags user data expected_code (all hex)
# flags bits: 4 de, 3 line_first, 2 line_last, 1 pixel_first, 0 pixel_last
T reset_identity
R 00 527a0120
R 01 00010000
W 00 ffffffff
R 00 527a0120
R 04 3
R 05 0
R 07 0
R 08 7f
R 09 0
R 0a 0
R 0b 3
R 18 7f
R 19 0
R 1a 0
R 1b 3
R 02 0
R 1f 0
R ff 0
T threshold_rule
P 1a 1 90 3
P 18 2 7f 3
P 18 3 7e 0
P 19 4 00 0
P 16 5 80 3
P 14 6 ff 3
P 15 7 01 0
R 07 1
R 05 1
R 04 3
T deferred_update
W 08 40
W 0a 1
W 0b 2
W 04 7
P 16 0 50 0
P 14 1 30 0
P 15 2 90 3
P 1a 3 50 2
P 18 4 3f 1
P 19 5 40 2
R 04 5
R 07 2
R 08 40
R 18 40
R 19 0
R 1a 1
R 1b 2
T inversion_and_codes
W 09 1
W 04 7
P 1a 0 40 1
P 18 0 3f 2
P 18 0 ff 1
P 19 0 00 2
R 07 3
R 19 1
R 04 5
W 04 6
P 1a 0 00 1
P 19 0 ff 1
R 07 0
R 05 0
R 04 4
T pass_through
P 1a a 12 1
P 18 5 34 1
P 08 f 56 1
P 19 c 78 1
P 16 3 9a 1
P 04 0 bc 1
P 15 9 de 1
R 07 0
